/* hw/cpuPkg.sv */
`default_nettype none

package cpuPkg;

  localparam int dataBits  = 32;
  localparam int regNoBits = 4;
  localparam int hexBits   = 24;
  localparam int ledrBits  = 10;

  // ====================
  // Primary opcodes
  // ====================
  localparam logic [5:0] op1AluR = 6'b000000;
  localparam logic [5:0] op1Beq  = 6'b001000;
  localparam logic [5:0] op1Blt  = 6'b001001;
  localparam logic [5:0] op1Ble  = 6'b001010;
  localparam logic [5:0] op1Bne  = 6'b001011;
  localparam logic [5:0] op1Jal  = 6'b001100;
  localparam logic [5:0] op1Lw   = 6'b010010;
  localparam logic [5:0] op1Sw   = 6'b011010;
  localparam logic [5:0] op1Addi = 6'b100000;
  localparam logic [5:0] op1Andi = 6'b100100;
  localparam logic [5:0] op1Ori  = 6'b100101;
  localparam logic [5:0] op1Xori = 6'b100110;

  // ====================
  // Register ALU functions
  // ====================
  localparam logic [7:0] op2Eq   = 8'b00001000;
  localparam logic [7:0] op2Lt   = 8'b00001001;
  localparam logic [7:0] op2Le   = 8'b00001010;
  localparam logic [7:0] op2Ne   = 8'b00001011;
  localparam logic [7:0] op2Add  = 8'b00100000;
  localparam logic [7:0] op2And  = 8'b00100100;
  localparam logic [7:0] op2Or   = 8'b00100101;
  localparam logic [7:0] op2Xor  = 8'b00100110;
  localparam logic [7:0] op2Sub  = 8'b00101000;
  localparam logic [7:0] op2Nand = 8'b00101100;
  localparam logic [7:0] op2Nor  = 8'b00101101;
  localparam logic [7:0] op2Nxor = 8'b00101110;
  localparam logic [7:0] op2Rshf = 8'b00110000;
  localparam logic [7:0] op2Lshf = 8'b00110001;

  // Memory-mapped output registers
  localparam logic [dataBits-1:0] addrHex       = 32'hFFFFF000;
  localparam logic [dataBits-1:0] addrLedr      = 32'hFFFFF020;
  localparam logic [hexBits-1:0]  hexResetValue = 24'hFEDEAD;

  // Same word seen as register form or immediate form
  typedef union packed {
    struct packed {
      logic [5:0]           op1;
      logic [7:0]           op2;
      logic [5:0]           unused;
      logic [regNoBits-1:0] rd;
      logic [regNoBits-1:0] rs;
      logic [regNoBits-1:0] rt;
    } r;
    struct packed {
      logic [5:0]           op1;
      logic [1:0]           unused;
      logic [15:0]          imm;
      logic [regNoBits-1:0] rs;
      logic [regNoBits-1:0] rt;
    } i;
  } instrWord_t;

endpackage

`default_nettype wire

/* hw/instrMem.sv */
`timescale 1ns/1ps
`default_nettype none

module instrMem #(
  parameter int imemAddrBits = 10
) (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         wbCyc,
  input  wire                         wbStb,
  input  wire [cpuPkg::dataBits-1:0]  wbAdr,
  input  wire [cpuPkg::dataBits-1:0]  wbDatW,
  output logic                        wbAck,
  input  wire [cpuPkg::dataBits-1:0]  fetchPc,
  output logic [cpuPkg::dataBits-1:0] fetchInstr
);

  logic [cpuPkg::dataBits-1:0] mem [2 ** (imemAddrBits - 2)];
  logic                        loadStrobe;

  // One write per request, ack drops again on the following edge
  assign loadStrobe = wbCyc && wbStb && !wbAck;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wbAck <= 1'b0;
    end else begin
      wbAck <= loadStrobe;
    end
  end

  always_ff @(posedge clk) begin
    if (loadStrobe) begin
      mem[wbAdr[imemAddrBits-1:2]] <= wbDatW;
    end
  end

  // Fetch read is asynchronous
  assign fetchInstr = mem[fetchPc[imemAddrBits-1:2]];

  ackNeedsStb: assert property (@(posedge clk) disable iff (reset) wbAck |-> $past(wbStb));

endmodule

`default_nettype wire

/* hw/fetchStage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
  parameter logic [cpuPkg::dataBits-1:0] startPc = 32'h100
) (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         run,
  input  wire                         stall,
  input  wire                         redirect,
  input  wire [cpuPkg::dataBits-1:0]  redirectPc,
  output logic [cpuPkg::dataBits-1:0] fetchPc,
  input  wire [cpuPkg::dataBits-1:0]  fetchInstr,
  output logic [cpuPkg::dataBits-1:0] fePc,
  output logic [cpuPkg::dataBits-1:0] fePcNext,
  output cpuPkg::instrWord_t          feInstr
);

  logic [cpuPkg::dataBits-1:0] pcPlus4;

  assign pcPlus4 = fetchPc + 32'd4;

  // Held at the start address while a program is loaded
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fetchPc <= startPc;
    end else if (!run) begin
      fetchPc <= startPc;
    end else if (redirect) begin
      fetchPc <= redirectPc;
    end else if (!stall) begin
      fetchPc <= pcPlus4;
    end
  end

  // An all-zero word in the fetch latch is a bubble
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      feInstr <= '0;
    end else if (redirect || !run) begin
      feInstr <= '0;
    end else if (!stall) begin
      feInstr <= fetchInstr;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      fePc     <= fetchPc;
      fePcNext <= pcPlus4;
    end
  end

endmodule

`default_nettype wire

/* hw/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  wire                          clk,
  input  wire                          reset,
  input  wire [cpuPkg::regNoBits-1:0]  rsNo,
  input  wire [cpuPkg::regNoBits-1:0]  rtNo,
  output logic [cpuPkg::dataBits-1:0]  rsValue,
  output logic [cpuPkg::dataBits-1:0]  rtValue,
  input  wire                          wbWrite,
  input  wire [cpuPkg::regNoBits-1:0]  wbRegNo,
  input  wire [cpuPkg::dataBits-1:0]   wbValue
);

  logic [cpuPkg::dataBits-1:0] regs [2 ** cpuPkg::regNoBits];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 2 ** cpuPkg::regNoBits; i++) begin
        regs[i] <= '0;
      end
    end else if (wbWrite) begin
      regs[wbRegNo] <= wbValue;
    end
  end

  // Write-through so decode sees the value retiring this cycle
  assign rsValue = (wbWrite && wbRegNo == rsNo) ? wbValue : regs[rsNo];
  assign rtValue = (wbWrite && wbRegNo == rtNo) ? wbValue : regs[rtNo];

endmodule

`default_nettype wire

/* hw/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
  input  wire                          clk,
  input  wire                          reset,
  input  wire cpuPkg::instrWord_t      feInstr,
  input  wire [cpuPkg::dataBits-1:0]   fePc,
  input  wire [cpuPkg::dataBits-1:0]   fePcNext,
  output logic [cpuPkg::regNoBits-1:0] rsNo,
  output logic [cpuPkg::regNoBits-1:0] rtNo,
  input  wire [cpuPkg::dataBits-1:0]   rsValue,
  input  wire [cpuPkg::dataBits-1:0]   rtValue,
  input  wire [cpuPkg::dataBits-1:0]   exAluResult,
  input  wire [cpuPkg::dataBits-1:0]   memResult,
  input  wire                          exWrReg,
  input  wire                          exIsLoad,
  input  wire [cpuPkg::regNoBits-1:0]  exWregNo,
  input  wire                          redirect,
  output logic                         stall,
  output logic [5:0]                   idOp1,
  output logic [7:0]                   idOp2,
  output logic [cpuPkg::dataBits-1:0]  idPc,
  output logic [cpuPkg::dataBits-1:0]  idPcNext,
  output logic [cpuPkg::dataBits-1:0]  idOpA,
  output logic [cpuPkg::dataBits-1:0]  idOpB,
  output logic [cpuPkg::dataBits-1:0]  idImm,
  output logic [cpuPkg::regNoBits-1:0] idWregNo,
  output logic                         idIsBranch,
  output logic                         idIsJal,
  output logic                         idMemRead,
  output logic                         idMemWrite,
  output logic                         idWrReg
);

  logic [5:0]                   op1;
  logic                         isAluR, isBranch, isJal, isLoad, isStore, isImmAlu;
  logic                         isNop, useRt, wrReg, loadLatch;
  logic [cpuPkg::regNoBits-1:0] wregNo;
  logic [cpuPkg::dataBits-1:0]  immExt, opA, opB;

  // ====================
  // Decode
  // ====================
  assign op1    = feInstr.r.op1;
  assign rsNo   = feInstr.r.rs;
  assign rtNo   = feInstr.r.rt;
  assign immExt = {{16{feInstr.i.imm[15]}}, feInstr.i.imm};

  assign isAluR   = op1 == cpuPkg::op1AluR;
  assign isBranch = op1 inside {cpuPkg::op1Beq, cpuPkg::op1Blt, cpuPkg::op1Ble, cpuPkg::op1Bne};
  assign isJal    = op1 == cpuPkg::op1Jal;
  assign isLoad   = op1 == cpuPkg::op1Lw;
  assign isStore  = op1 == cpuPkg::op1Sw;
  assign isImmAlu = op1 inside {cpuPkg::op1Addi, cpuPkg::op1Andi, cpuPkg::op1Ori, cpuPkg::op1Xori};
  assign isNop    = feInstr == '0;

  // Register form writes rd and everything else writes rt
  assign wregNo = isAluR ? feInstr.r.rd : feInstr.r.rt;
  assign wrReg  = !(isBranch || isStore || isNop);
  assign useRt  = !(isJal || isLoad || isImmAlu);

  // ====================
  // Hazards
  // ====================
  // A load in execute has no data before the memory stage
  assign stall = idMemRead && idWrReg &&
                 (idWregNo == rsNo || (useRt && idWregNo == rtNo));

  // Youngest producer wins
  assign opA = (idWrReg && idWregNo == rsNo) ? exAluResult :
               (exWrReg && exWregNo == rsNo) ? memResult : rsValue;
  assign opB = (idWrReg && idWregNo == rtNo) ? exAluResult :
               (exWrReg && exWregNo == rtNo) ? memResult : rtValue;

  assign loadLatch = !(stall || redirect);

  // ====================
  // Decode latch
  // ====================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      idOp1      <= '0;
      idIsBranch <= 1'b0;
      idIsJal    <= 1'b0;
      idMemRead  <= 1'b0;
      idMemWrite <= 1'b0;
      idWrReg    <= 1'b0;
    end else begin
      idOp1      <= loadLatch ? op1 : '0;
      idIsBranch <= loadLatch && isBranch;
      idIsJal    <= loadLatch && isJal;
      idMemRead  <= loadLatch && isLoad;
      idMemWrite <= loadLatch && isStore;
      idWrReg    <= loadLatch && wrReg;
    end
  end

  always_ff @(posedge clk) begin
    idOp2    <= feInstr.r.op2;
    idWregNo <= wregNo;
    idPc     <= fePc;
    idPcNext <= fePcNext;
    idOpA    <= opA;
    idOpB    <= opB;
    idImm    <= immExt;
  end

  // A load and a redirecting instruction never share the execute stage
  stallNotRedirect: assert property (@(posedge clk) disable iff (reset) !(stall && redirect));

endmodule

`default_nettype wire

/* hw/aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
  input  wire [5:0]                   op1,
  input  wire [7:0]                   op2,
  input  wire [cpuPkg::dataBits-1:0]  opA,
  input  wire [cpuPkg::dataBits-1:0]  opB,
  input  wire [cpuPkg::dataBits-1:0]  imm,
  input  wire [cpuPkg::dataBits-1:0]  pcNext,
  output logic [cpuPkg::dataBits-1:0] result
);

  localparam int width = cpuPkg::dataBits;

  logic [width-1:0] regResult;

  // Comparisons are signed, shifts are logical
  always_comb begin
    case (op2)
      cpuPkg::op2Eq:   regResult = width'(opA == opB);
      cpuPkg::op2Lt:   regResult = width'($signed(opA) < $signed(opB));
      cpuPkg::op2Le:   regResult = width'($signed(opA) <= $signed(opB));
      cpuPkg::op2Ne:   regResult = width'(opA != opB);
      cpuPkg::op2Add:  regResult = opA + opB;
      cpuPkg::op2And:  regResult = opA & opB;
      cpuPkg::op2Or:   regResult = opA | opB;
      cpuPkg::op2Xor:  regResult = opA ^ opB;
      cpuPkg::op2Sub:  regResult = opA - opB;
      cpuPkg::op2Nand: regResult = ~(opA & opB);
      cpuPkg::op2Nor:  regResult = ~(opA | opB);
      cpuPkg::op2Nxor: regResult = opA ~^ opB;
      cpuPkg::op2Rshf: regResult = opA >> opB[$clog2(width)-1:0];
      cpuPkg::op2Lshf: regResult = opA << opB[$clog2(width)-1:0];
      default:         regResult = '0;
    endcase
  end

  always_comb begin
    case (op1)
      cpuPkg::op1AluR: result = regResult;
      cpuPkg::op1Lw,
      cpuPkg::op1Sw,
      cpuPkg::op1Addi: result = opA + imm;
      cpuPkg::op1Andi: result = opA & imm;
      cpuPkg::op1Ori:  result = opA | imm;
      cpuPkg::op1Xori: result = opA ^ imm;
      cpuPkg::op1Jal:  result = pcNext;  // link value
      default:         result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hw/branchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module branchUnit (
  input  wire [5:0]                   op1,
  input  wire                         isJal,
  input  wire [cpuPkg::dataBits-1:0]  opA,
  input  wire [cpuPkg::dataBits-1:0]  opB,
  input  wire [cpuPkg::dataBits-1:0]  imm,
  input  wire [cpuPkg::dataBits-1:0]  pcNext,
  output logic                        taken,
  output logic [cpuPkg::dataBits-1:0] target
);

  logic cond;

  always_comb begin
    case (op1)
      cpuPkg::op1Beq: cond = opA == opB;
      cpuPkg::op1Blt: cond = $signed(opA) < $signed(opB);
      cpuPkg::op1Ble: cond = $signed(opA) <= $signed(opB);
      cpuPkg::op1Bne: cond = opA != opB;
      default:        cond = 1'b0;
    endcase
  end

  assign taken = isJal || cond;

  // Offset counts words, JAL is relative to rs
  assign target = (isJal ? opA : pcNext) + {imm[cpuPkg::dataBits-3:0], 2'b00};

endmodule

`default_nettype wire

/* hw/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
  input  wire                          clk,
  input  wire                          reset,
  input  wire [5:0]                    idOp1,
  input  wire [7:0]                    idOp2,
  input  wire [cpuPkg::dataBits-1:0]   idPc,
  input  wire [cpuPkg::dataBits-1:0]   idPcNext,
  input  wire [cpuPkg::dataBits-1:0]   idOpA,
  input  wire [cpuPkg::dataBits-1:0]   idOpB,
  input  wire [cpuPkg::dataBits-1:0]   idImm,
  input  wire [cpuPkg::regNoBits-1:0]  idWregNo,
  input  wire                          idIsBranch,
  input  wire                          idIsJal,
  input  wire                          idMemRead,
  input  wire                          idMemWrite,
  input  wire                          idWrReg,
  output logic [cpuPkg::dataBits-1:0]  exAluResult,
  output logic                         redirect,
  output logic [cpuPkg::dataBits-1:0]  redirectPc,
  output logic [cpuPkg::dataBits-1:0]  exStoreData,
  output logic [cpuPkg::regNoBits-1:0] exWregNo,
  output logic                         exWrReg,
  output logic                         exIsLoad,
  output logic                         exMemRead,
  output logic                         exMemWrite
);

  logic branchTaken;

  aluUnit alu (
    .op1    (idOp1),
    .op2    (idOp2),
    .opA    (idOpA),
    .opB    (idOpB),
    .imm    (idImm),
    .pcNext (idPcNext),
    .result (exAluResult)
  );

  branchUnit branch (
    .op1    (idOp1),
    .isJal  (idIsJal),
    .opA    (idOpA),
    .opB    (idOpB),
    .imm    (idImm),
    .pcNext (idPcNext),
    .taken  (branchTaken),
    .target (redirectPc)
  );

  // Only real control transfers may steer fetch
  assign redirect = (idIsBranch || idIsJal) && branchTaken;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      exWregNo   <= '0;
      exWrReg    <= 1'b0;
      exMemRead  <= 1'b0;
      exMemWrite <= 1'b0;
    end else begin
      exWregNo   <= idWregNo;
      exWrReg    <= idWrReg;
      exMemRead  <= idMemRead;
      exMemWrite <= idMemWrite;
    end
  end

  always_ff @(posedge clk) begin
    exStoreData <= idOpB;
  end

  assign exIsLoad = exMemRead;

  redirectAligned: assert property (@(posedge clk) disable iff (reset)
    redirect |-> redirectPc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* hw/memStage.sv */
`timescale 1ns/1ps
`default_nettype none

module memStage #(
  parameter int dmemAddrBits = 10
) (
  input  wire                          clk,
  input  wire                          reset,
  input  wire [cpuPkg::dataBits-1:0]   exAluResult,
  input  wire [cpuPkg::dataBits-1:0]   exStoreData,
  input  wire                          exMemRead,
  input  wire                          exMemWrite,
  input  wire                          exWrReg,
  input  wire [cpuPkg::regNoBits-1:0]  exWregNo,
  output logic [cpuPkg::dataBits-1:0]  memResult,
  output logic                         wbWrite,
  output logic [cpuPkg::regNoBits-1:0] wbRegNo,
  output logic [cpuPkg::dataBits-1:0]  wbValue,
  output logic [cpuPkg::hexBits-1:0]   hex,
  output logic [cpuPkg::ledrBits-1:0]  ledr
);

  logic [cpuPkg::dataBits-1:0] dmem [2 ** (dmemAddrBits - 2)];
  logic [cpuPkg::dataBits-1:0] memAddr;
  logic [cpuPkg::dataBits-1:0] loadData;
  logic                        hexSel, ledrSel;

  assign hexSel    = memAddr == cpuPkg::addrHex;
  assign ledrSel   = memAddr == cpuPkg::addrLedr;
  assign loadData  = dmem[memAddr[dmemAddrBits-1:2]];
  assign memResult = exMemRead ? loadData : memAddr;

  // ====================
  // Stores
  // ====================
  always_ff @(posedge clk) begin
    if (exMemWrite && !hexSel && !ledrSel) begin
      dmem[memAddr[dmemAddrBits-1:2]] <= exStoreData;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hex  <= cpuPkg::hexResetValue;
      ledr <= '0;
    end else if (exMemWrite) begin
      if (hexSel) begin
        hex <= exStoreData[cpuPkg::hexBits-1:0];
      end
      if (ledrSel) begin
        ledr <= exStoreData[cpuPkg::ledrBits-1:0];
      end
    end
  end

  // ====================
  // Write-back latch
  // ====================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wbWrite <= 1'b0;
      wbRegNo <= '0;
    end else begin
      wbWrite <= exWrReg;
      wbRegNo <= exWregNo;
    end
  end

  // Address comes in from execute on the same edge as its controls
  always_ff @(posedge clk) begin
    memAddr <= exAluResult;
    wbValue <= memResult;
  end

endmodule

`default_nettype wire

/* hw/cpuTop.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTop #(
  parameter logic [cpuPkg::dataBits-1:0] startPc = 32'h100,
  parameter int imemAddrBits = 10,
  parameter int dmemAddrBits = 10
) (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         run,
  input  wire                         wbCyc,
  input  wire                         wbStb,
  input  wire [cpuPkg::dataBits-1:0]  wbAdr,
  input  wire [cpuPkg::dataBits-1:0]  wbDatW,
  output logic                        wbAck,
  output logic [cpuPkg::hexBits-1:0]  hex,
  output logic [cpuPkg::ledrBits-1:0] ledr
);

  // Fetch
  logic [cpuPkg::dataBits-1:0]  fetchPc, fetchInstr, fePc, fePcNext;
  cpuPkg::instrWord_t           feInstr;

  // Decode and register file
  logic [cpuPkg::regNoBits-1:0] rsNo, rtNo, idWregNo;
  logic [cpuPkg::dataBits-1:0]  rsValue, rtValue;
  logic                         stall;
  logic [5:0]                   idOp1;
  logic [7:0]                   idOp2;
  logic [cpuPkg::dataBits-1:0]  idPc, idPcNext, idOpA, idOpB, idImm;
  logic                         idIsBranch, idIsJal, idMemRead, idMemWrite, idWrReg;

  // Execute
  logic [cpuPkg::dataBits-1:0]  exAluResult, redirectPc, exStoreData;
  logic                         redirect, exWrReg, exIsLoad, exMemRead, exMemWrite;
  logic [cpuPkg::regNoBits-1:0] exWregNo;

  // Memory and write-back
  logic [cpuPkg::dataBits-1:0]  memResult, wbValue;
  logic                         wbWrite;
  logic [cpuPkg::regNoBits-1:0] wbRegNo;

  instrMem #(.imemAddrBits(imemAddrBits)) imem (.*);

  fetchStage #(.startPc(startPc)) fetch (.*);

  regFile regs (.*);

  decodeStage decode (.*);

  executeStage execute (.*);

  memStage #(.dmemAddrBits(dmemAddrBits)) mem (.*);

endmodule

`default_nettype wire

/* verification/tbClock.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
  parameter int periodNs = 8
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always begin
    #(periodNs / 2.0) clk = ~clk;
  end

endmodule

`default_nettype wire

/* verification/cpuTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

  localparam logic [31:0] startPc    = 32'h100;
  localparam int          numRows    = 13;
  localparam int          maxWords   = 16;
  localparam int          cycleLimit = numRows * (maxWords * 12 + 204) + 50;

  // Sign extension turns these offsets into FFFFF020 and FFFFF000
  localparam logic [15:0] ledrOff = 16'hF020;
  localparam logic [15:0] hexOff  = 16'hF000;

  wire         clk;
  logic        reset, run, wbCyc, wbStb;
  logic [31:0] wbAdr, wbDatW;
  wire         wbAck;
  wire  [23:0] hex;
  wire  [9:0]  ledr;

  // ====================
  // Stimulus table
  // ====================
  logic [31:0] progWords [numRows][maxWords];
  int          progLen [numRows];
  logic [9:0]  expLedr [numRows];
  logic [23:0] expHex [numRows];

  int errorCount  = 0;
  int checkCount  = 0;
  int ackCount    = 0;
  int wordsLoaded = 0;
  int cycleCount;

  tbClock #(.periodNs(8)) clockGen (.clk(clk));

  cpuTop #(.startPc(startPc)) UUT (
    .clk    (clk),
    .reset  (reset),
    .run    (run),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbAdr  (wbAdr),
    .wbDatW (wbDatW),
    .wbAck  (wbAck),
    .hex    (hex),
    .ledr   (ledr)
  );

  function automatic logic [31:0] immWord(input logic [5:0] op1, input int rs, input int rt,
                                          input logic [15:0] imm);
    cpuPkg::instrWord_t w;
    w       = '0;
    w.i.op1 = op1;
    w.i.imm = imm;
    w.i.rs  = 4'(rs);
    w.i.rt  = 4'(rt);
    return w;
  endfunction

  function automatic logic [31:0] regWord(input logic [7:0] op2, input int rd, input int rs,
                                          input int rt);
    cpuPkg::instrWord_t w;
    w       = '0;
    w.r.op1 = cpuPkg::op1AluR;
    w.r.op2 = op2;
    w.r.rd  = 4'(rd);
    w.r.rs  = 4'(rs);
    w.r.rt  = 4'(rt);
    return w;
  endfunction

  task automatic appendWord(input int row, input logic [31:0] word);
    progWords[row][progLen[row]] = word;
    progLen[row]++;
  endtask

  // Parks the core on a JAL to its own address, built from r0 and the word address
  task automatic finishRow(input int row, input logic [9:0] ledrValue,
                           input logic [23:0] hexValue);
    appendWord(row, immWord(cpuPkg::op1Jal, 0, 15, 16'((startPc >> 2) + progLen[row])));
    expLedr[row] = ledrValue;
    expHex[row]  = hexValue;
  endtask

  // r3 = r1 fnLedr r2 goes to ledr and r4 = r1 fnHex r2 goes to hex
  task automatic aluPairRow(input int row, input logic [15:0] a, input logic [15:0] b,
                            input logic [7:0] fnLedr, input logic [7:0] fnHex,
                            input logic [9:0] ledrValue, input logic [23:0] hexValue);
    appendWord(row, immWord(cpuPkg::op1Addi, 0, 1, a));
    appendWord(row, immWord(cpuPkg::op1Addi, 0, 2, b));
    appendWord(row, regWord(fnLedr, 3, 1, 2));
    appendWord(row, regWord(fnHex, 4, 1, 2));
    appendWord(row, immWord(cpuPkg::op1Sw, 0, 3, ledrOff));
    appendWord(row, immWord(cpuPkg::op1Sw, 0, 4, hexOff));
    finishRow(row, ledrValue, hexValue);
  endtask

  task automatic padPair(input int row);
    appendWord(row, immWord(cpuPkg::op1Addi, 0, 9, 16'h0055));
    appendWord(row, immWord(cpuPkg::op1Addi, 0, 10, 16'h0066));
  endtask

  // Dependent chain 3, 6, 30h, 33h and 1033h with or without spacing
  task automatic chainRow(input int row, input bit padded);
    appendWord(row, immWord(cpuPkg::op1Addi, 0, 1, 16'd3));
    if (padded) padPair(row);
    appendWord(row, regWord(cpuPkg::op2Add, 2, 1, 1));
    if (padded) padPair(row);
    appendWord(row, regWord(cpuPkg::op2Lshf, 2, 2, 1));
    if (padded) padPair(row);
    appendWord(row, regWord(cpuPkg::op2Add, 3, 2, 1));
    if (padded) padPair(row);
    appendWord(row, immWord(cpuPkg::op1Addi, 3, 4, 16'h1000));
    appendWord(row, immWord(cpuPkg::op1Sw, 0, 3, ledrOff));
    appendWord(row, immWord(cpuPkg::op1Sw, 0, 4, hexOff));
    finishRow(row, 10'h033, 24'h001033);
  endtask

  task automatic buildTable();
    for (int row = 0; row < numRows; row++) begin
      progLen[row] = 0;
    end
    aluPairRow(0, 16'hFFFD, 16'd5, cpuPkg::op2Lt, cpuPkg::op2Add, 10'h001, 24'h000002);
    aluPairRow(1, 16'd5, 16'hFFFD, cpuPkg::op2Le, cpuPkg::op2Sub, 10'h000, 24'h000008);
    aluPairRow(2, 16'd7, 16'd7, cpuPkg::op2Eq, cpuPkg::op2Ne, 10'h001, 24'h000000);
    aluPairRow(3, 16'h00F0, 16'h003C, cpuPkg::op2And, cpuPkg::op2Or, 10'h030, 24'h0000FC);
    aluPairRow(4, 16'h00F0, 16'h003C, cpuPkg::op2Xor, cpuPkg::op2Nand, 10'h0CC, 24'hFFFFCF);
    aluPairRow(5, 16'h00F0, 16'h003C, cpuPkg::op2Nor, cpuPkg::op2Nxor, 10'h303, 24'hFFFF33);
    aluPairRow(6, 16'h1234, 16'd4, cpuPkg::op2Rshf, cpuPkg::op2Lshf, 10'h123, 24'h012340);

    // Immediate forms count 100h down by one and then mask with sign-extended values
    appendWord(7, immWord(cpuPkg::op1Addi, 0, 1, 16'h0100));
    appendWord(7, immWord(cpuPkg::op1Addi, 1, 1, 16'hFFFF));
    appendWord(7, immWord(cpuPkg::op1Andi, 1, 2, 16'hFF0F));
    appendWord(7, immWord(cpuPkg::op1Ori, 2, 3, 16'h0300));
    appendWord(7, immWord(cpuPkg::op1Xori, 3, 4, 16'hFFFF));
    appendWord(7, immWord(cpuPkg::op1Sw, 0, 3, ledrOff));
    appendWord(7, immWord(cpuPkg::op1Sw, 0, 4, hexOff));
    finishRow(7, 10'h30F, 24'hFFFCF0);

    chainRow(8, 1'b0);
    chainRow(9, 1'b1);

    // Store and load back, then use the loaded value at once in both operand slots
    appendWord(10, immWord(cpuPkg::op1Addi, 0, 1, 16'h02A5));
    appendWord(10, immWord(cpuPkg::op1Addi, 0, 2, 16'h0040));
    appendWord(10, immWord(cpuPkg::op1Sw, 2, 1, 16'h0000));
    appendWord(10, immWord(cpuPkg::op1Lw, 2, 3, 16'h0000));
    appendWord(10, immWord(cpuPkg::op1Addi, 3, 4, 16'h0001));
    appendWord(10, immWord(cpuPkg::op1Sw, 0, 4, ledrOff));
    appendWord(10, immWord(cpuPkg::op1Lw, 2, 5, 16'h0000));
    appendWord(10, regWord(cpuPkg::op2Add, 6, 5, 5));
    appendWord(10, immWord(cpuPkg::op1Sw, 0, 6, hexOff));
    finishRow(10, 10'h2A6, 24'h00054A);

    // Each taken branch skips a store of 3FFh to ledr
    appendWord(11, immWord(cpuPkg::op1Addi, 0, 1, 16'hFFFE));
    appendWord(11, immWord(cpuPkg::op1Addi, 0, 2, 16'd3));
    appendWord(11, immWord(cpuPkg::op1Addi, 0, 5, 16'h03FF));
    appendWord(11, immWord(cpuPkg::op1Addi, 0, 6, 16'h0155));
    appendWord(11, immWord(cpuPkg::op1Sw, 0, 6, ledrOff));
    appendWord(11, immWord(cpuPkg::op1Beq, 1, 1, 16'd1));
    appendWord(11, immWord(cpuPkg::op1Sw, 0, 5, ledrOff));
    appendWord(11, immWord(cpuPkg::op1Blt, 1, 2, 16'd1));
    appendWord(11, immWord(cpuPkg::op1Sw, 0, 5, ledrOff));
    appendWord(11, immWord(cpuPkg::op1Ble, 2, 2, 16'd1));
    appendWord(11, immWord(cpuPkg::op1Sw, 0, 5, ledrOff));
    appendWord(11, immWord(cpuPkg::op1Bne, 1, 2, 16'd1));
    appendWord(11, immWord(cpuPkg::op1Sw, 0, 5, ledrOff));
    appendWord(11, immWord(cpuPkg::op1Sw, 0, 1, hexOff));
    finishRow(11, 10'h155, 24'hFFFFFE);

    // Untaken branches fall through
    // JAL at 128h jumps to r1 + 34h
    appendWord(12, immWord(cpuPkg::op1Addi, 0, 1, 16'h0100));
    appendWord(12, immWord(cpuPkg::op1Addi, 0, 2, 16'h0104));
    appendWord(12, immWord(cpuPkg::op1Beq, 1, 2, 16'd1));
    appendWord(12, immWord(cpuPkg::op1Addi, 0, 3, 16'h0011));
    appendWord(12, immWord(cpuPkg::op1Blt, 2, 1, 16'd1));
    appendWord(12, immWord(cpuPkg::op1Addi, 3, 3, 16'd2));
    appendWord(12, immWord(cpuPkg::op1Ble, 2, 1, 16'd1));
    appendWord(12, immWord(cpuPkg::op1Addi, 3, 3, 16'd4));
    appendWord(12, immWord(cpuPkg::op1Bne, 1, 1, 16'd1));
    appendWord(12, immWord(cpuPkg::op1Addi, 3, 3, 16'd8));
    appendWord(12, immWord(cpuPkg::op1Jal, 1, 7, 16'd13));
    appendWord(12, immWord(cpuPkg::op1Addi, 3, 3, 16'h0040));
    appendWord(12, immWord(cpuPkg::op1Addi, 0, 7, 16'h0077));
    appendWord(12, immWord(cpuPkg::op1Sw, 0, 7, hexOff));
    appendWord(12, immWord(cpuPkg::op1Sw, 0, 3, ledrOff));
    finishRow(12, 10'h01F, 24'h00012C);
  endtask

  // ====================
  // Checks and bus access
  // ====================
  task automatic checkValue(input string what, input logic [31:0] got,
                            input logic [31:0] expected);
    checkCount++;
    if (got !== expected) begin
      errorCount++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  task automatic writeWord(input logic [31:0] addr, input logic [31:0] data);
    int waitCycles;
    @(negedge clk);
    wbCyc      = 1'b1;
    wbStb      = 1'b1;
    wbAdr      = addr;
    wbDatW     = data;
    waitCycles = 0;
    do begin
      @(negedge clk);
      waitCycles++;
    end while (wbAck !== 1'b1 && waitCycles < 10);
    if (wbAck !== 1'b1) begin
      errorCount++;
      $display("No Wishbone ack within 10 cycles for the write to address %h", addr);
    end
    wbCyc = 1'b0;
    wbStb = 1'b0;
  endtask

  task automatic runRow(input int row);
    @(negedge clk);
    run = 1'b0;
    // Previous program drains out of the pipeline
    repeat (4) @(negedge clk);
    for (int idx = 0; idx < progLen[row]; idx++) begin
      writeWord(startPc + 32'(4 * idx), progWords[row][idx]);
      wordsLoaded++;
    end
    @(negedge clk);
    run = 1'b1;
    repeat (200) @(negedge clk);
    checkValue($sformatf("row %0d ledr", row), 32'(ledr), 32'(expLedr[row]));
    checkValue($sformatf("row %0d hex", row), 32'(hex), 32'(expHex[row]));
    checkValue($sformatf("row %0d ack count", row), ackCount, wordsLoaded);
  endtask

  // One ack per loaded word
  always @(posedge clk) begin
    if (wbAck === 1'b1) begin
      ackCount++;
    end
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Run stopped after %0d cycles before the tests were finished", cycleCount);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    reset  = 1'b1;
    run    = 1'b0;
    wbCyc  = 1'b0;
    wbStb  = 1'b0;
    wbAdr  = '0;
    wbDatW = '0;
    buildTable();
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Idle outputs before any program
    checkValue("ledr after reset", 32'(ledr), 32'h0);
    checkValue("hex after reset", 32'(hex), 32'hFEDEAD);
    checkValue("wbAck after reset", 32'(wbAck), 32'h0);

    for (int row = 0; row < numRows; row++) begin
      runRow(row);
    end

    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
hw/cpuPkg.sv
hw/instrMem.sv
hw/fetchStage.sv
hw/regFile.sv
hw/decodeStage.sv
hw/aluUnit.sv
hw/branchUnit.sv
hw/executeStage.sv
hw/memStage.sv
hw/cpuTop.sv
verification/tbClock.sv
verification/cpuTb.sv

/* Bender.yml */
package:
  name: pipelinedCpu

dependencies: {}

sources:
  - hw/cpuPkg.sv
  - hw/instrMem.sv
  - hw/fetchStage.sv
  - hw/regFile.sv
  - hw/decodeStage.sv
  - hw/aluUnit.sv
  - hw/branchUnit.sv
  - hw/executeStage.sv
  - hw/memStage.sv
  - hw/cpuTop.sv
  - target: test
    files:
      - verification/tbClock.sv
      - verification/cpuTb.sv
